// File: hw/ref_pkg.sv
package ref_pkg;

  // pixel and line geometry
  localparam int PIX_W = 8;
  localparam int LINE_PIX = 16;
  localparam int LINE_W = LINE_PIX * PIX_W;

  // reference line storage
  localparam int REF_DEPTH = 4096;
  localparam int ADDR_W = $clog2(REF_DEPTH);

  // lines between two vertically adjacent picture rows
  localparam int ROW_STRIDE = 16;

  // fetch window, 9x9 pixels around a 4x4 block
  localparam int WIN = 9;
  localparam int WIN_ABOVE = 2;
  localparam int WIN_W = WIN * PIX_W;

  // pixel position of the block inside its line
  localparam int POS_W = 4;

  // sideband fields
  localparam int MV_W = 11;
  localparam int SUBBLK = 16;
  localparam int FRAC_W = 5;
  localparam int CUR_N = 4;
  localparam int CUR_ADDR_W = 13;

  // one reference line
  // raw view for storage, lane view for pixel alignment
  // lane k occupies bits 8k+7 down to 8k, lane 15 is the first pixel
  typedef union packed {
    logic [LINE_W-1:0] raw;
    logic [LINE_PIX-1:0][PIX_W-1:0] lane;
  } ref_line_t;

endpackage

// File: hw/ref_line_ram.sv
`timescale 1ns/1ps

module ref_line_ram (
  input  logic                             clk,
  input  logic                             load_ref_ram,
  input  logic [ref_pkg::ADDR_W-1:0]       load_addr,
  input  ref_pkg::ref_line_t               load_line,
  input  logic [ref_pkg::ADDR_W-1:0]       rd_addr [2*ref_pkg::WIN],
  output ref_pkg::ref_line_t               rd_line [2*ref_pkg::WIN]
);

  // line storage, contents undefined until written
  logic [ref_pkg::LINE_W-1:0] mem [ref_pkg::REF_DEPTH];

  // single line write port
  always_ff @(posedge clk)
  begin
    if (load_ref_ram)
    begin
      mem[load_addr] <= load_line.raw;
    end
  end

  // two ports per window row, hi and lo line of the pair
  // a fetch on the write edge still sees the old line
  always_comb
  begin
    for (int p = 0; p < 2 * ref_pkg::WIN; p++)
    begin
      rd_line[p].raw = mem[rd_addr[p]];
    end
  end

endmodule

// File: hw/ref_row_align.sv
`timescale 1ns/1ps

module ref_row_align (
  input  ref_pkg::ref_line_t               pair_hi,
  input  ref_pkg::ref_line_t               pair_lo,
  input  logic [4:0]                       start,
  output logic [ref_pkg::WIN_W-1:0]        row_pel
);

  // 32 pixel run, hi line first, each line from lane 15 down to lane 0
  logic [ref_pkg::PIX_W-1:0] run [2*ref_pkg::LINE_PIX];

  always_comb
  begin
    for (int k = 0; k < ref_pkg::LINE_PIX; k++)
    begin
      run[k] = pair_hi.lane[ref_pkg::LINE_PIX-1-k];
      run[ref_pkg::LINE_PIX+k] = pair_lo.lane[ref_pkg::LINE_PIX-1-k];
    end
  end

  // nine pixels from start onward, first pixel in the top byte
  always_comb
  begin : pick
    logic [4:0] idx;
    idx = '0;
    for (int m = 0; m < ref_pkg::WIN; m++)
    begin
      // start never exceeds 15, so the index stays inside the run
      idx = start + 5'(m);
      row_pel[(ref_pkg::WIN-1-m)*ref_pkg::PIX_W +: ref_pkg::PIX_W] = run[idx];
    end
  end

endmodule

// File: hw/ref_window_gather.sv
`timescale 1ns/1ps

module ref_window_gather (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic                             export_data_ref,
  input  logic [ref_pkg::ADDR_W-1:0]       ref_4para_addr,
  input  logic [ref_pkg::POS_W-1:0]        pos_4,
  output logic [ref_pkg::ADDR_W-1:0]       rd_addr [2*ref_pkg::WIN],
  input  ref_pkg::ref_line_t               rd_line [2*ref_pkg::WIN],
  output logic [ref_pkg::WIN_W-1:0]        ref_pel_4 [ref_pkg::WIN]
);

  // window starts two pixels ahead of the block position
  // positions 14 and 15 reach back into the previous line
  logic                        wrap_pair;
  logic [4:0]                  start;
  logic [ref_pkg::ADDR_W-1:0]  base [ref_pkg::WIN];
  logic [ref_pkg::WIN_W-1:0]   row_pel [ref_pkg::WIN];

  assign wrap_pair = (int'(pos_4) >= ref_pkg::LINE_PIX - 2);

  // pixel pos_4+2 of line b sits at run index 13-pos_4 when b is the hi line,
  // and one full line further when b is the lo line
  always_comb
  begin
    if (wrap_pair)
    begin
      start = 5'(2 * ref_pkg::LINE_PIX - 3 - int'(pos_4));
    end
    else
    begin
      start = 5'(ref_pkg::LINE_PIX - 3 - int'(pos_4));
    end
  end

  for (genvar r = 0; r < ref_pkg::WIN; r++)
  begin : g_row
    // row base line, wraps modulo the memory depth
    assign base[r] = ref_4para_addr
                   + ref_pkg::ADDR_W'((r - ref_pkg::WIN_ABOVE) * ref_pkg::ROW_STRIDE);

    // even port carries the hi line, odd port the lo line
    assign rd_addr[2*r]   = wrap_pair ? base[r] - ref_pkg::ADDR_W'(1) : base[r];
    assign rd_addr[2*r+1] = wrap_pair ? base[r] : base[r] + ref_pkg::ADDR_W'(1);

    ref_row_align u_align (
      .pair_hi (rd_line[2*r]),
      .pair_lo (rd_line[2*r+1]),
      .start   (start),
      .row_pel (row_pel[r])
    );
  end

  // window register, loads only on a fetch strobe
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ref_pel_4 <= '{default: '0};
    end
    else if (en && export_data_ref)
    begin
      ref_pel_4 <= row_pel;
    end
  end

endmodule

// File: hw/ref_sideband_fwd.sv
`timescale 1ns/1ps

module ref_sideband_fwd (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 export_data_ref,
  input  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_in [ref_pkg::CUR_N],
  output logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_out [ref_pkg::CUR_N],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_x_in [ref_pkg::SUBBLK],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_y_in [ref_pkg::SUBBLK],
  output logic signed [ref_pkg::MV_W-1:0]      mv_x_out [ref_pkg::SUBBLK],
  output logic signed [ref_pkg::MV_W-1:0]      mv_y_out [ref_pkg::SUBBLK],
  input  logic [ref_pkg::FRAC_W-1:0]           frac_x_in,
  input  logic [ref_pkg::FRAC_W-1:0]           frac_y_in,
  output logic [ref_pkg::FRAC_W-1:0]           frac_x_out,
  output logic [ref_pkg::FRAC_W-1:0]           frac_y_out,
  input  logic                                 enab_prof_in,
  output logic                                 enab_prof_out
);

  // block addresses and refinement enable
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cur_addr_out  <= '{default: '0};
      enab_prof_out <= 1'b0;
    end
    else if (export_data_ref)
    begin
      cur_addr_out  <= cur_addr_in;
      enab_prof_out <= enab_prof_in;
    end
  end

  // per sub-block motion vectors
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mv_x_out <= '{default: '0};
      mv_y_out <= '{default: '0};
    end
    else if (export_data_ref)
    begin
      mv_x_out <= mv_x_in;
      mv_y_out <= mv_y_in;
    end
  end

  // fractional parts, needed later by the interpolation filter
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frac_x_out <= '0;
      frac_y_out <= '0;
    end
    else if (export_data_ref)
    begin
      frac_x_out <= frac_x_in;
      frac_y_out <= frac_y_in;
    end
  end

endmodule

// File: hw/ref_fetch_top.sv
`timescale 1ns/1ps

module ref_fetch_top (
  input  logic                                 clk,
  input  logic                                 rst_n,

  // reference line load
  input  logic                                 load_ref_ram,
  input  logic [ref_pkg::ADDR_W-1:0]           load_addr,
  input  ref_pkg::ref_line_t                   load_line,

  // window fetch
  input  logic                                 en,
  input  logic                                 export_data_ref,
  input  logic [ref_pkg::ADDR_W-1:0]           ref_4para_addr,
  input  logic [ref_pkg::POS_W-1:0]            pos_4,
  output logic [ref_pkg::WIN_W-1:0]            ref_pel_4 [ref_pkg::WIN],

  // sideband forwarding
  input  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_in [ref_pkg::CUR_N],
  output logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_out [ref_pkg::CUR_N],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_x_in [ref_pkg::SUBBLK],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_y_in [ref_pkg::SUBBLK],
  output logic signed [ref_pkg::MV_W-1:0]      mv_x_out [ref_pkg::SUBBLK],
  output logic signed [ref_pkg::MV_W-1:0]      mv_y_out [ref_pkg::SUBBLK],
  input  logic [ref_pkg::FRAC_W-1:0]           frac_x_in,
  input  logic [ref_pkg::FRAC_W-1:0]           frac_y_in,
  output logic [ref_pkg::FRAC_W-1:0]           frac_x_out,
  output logic [ref_pkg::FRAC_W-1:0]           frac_y_out,
  input  logic                                 enab_prof_in,
  output logic                                 enab_prof_out
);

  // line pair read paths between gather and storage
  logic [ref_pkg::ADDR_W-1:0] rd_addr [2*ref_pkg::WIN];
  ref_pkg::ref_line_t         rd_line [2*ref_pkg::WIN];

  ref_line_ram u_ram (
    .clk          (clk),
    .load_ref_ram (load_ref_ram),
    .load_addr    (load_addr),
    .load_line    (load_line),
    .rd_addr      (rd_addr),
    .rd_line      (rd_line)
  );

  ref_window_gather u_gather (
    .clk             (clk),
    .rst_n           (rst_n),
    .en              (en),
    .export_data_ref (export_data_ref),
    .ref_4para_addr  (ref_4para_addr),
    .pos_4           (pos_4),
    .rd_addr         (rd_addr),
    .rd_line         (rd_line),
    .ref_pel_4       (ref_pel_4)
  );

  // sideband moves on every export, fetch enable or not
  ref_sideband_fwd u_sideband (
    .clk             (clk),
    .rst_n           (rst_n),
    .export_data_ref (export_data_ref),
    .cur_addr_in     (cur_addr_in),
    .cur_addr_out    (cur_addr_out),
    .mv_x_in         (mv_x_in),
    .mv_y_in         (mv_y_in),
    .mv_x_out        (mv_x_out),
    .mv_y_out        (mv_y_out),
    .frac_x_in       (frac_x_in),
    .frac_y_in       (frac_y_in),
    .frac_x_out      (frac_x_out),
    .frac_y_out      (frac_y_out),
    .enab_prof_in    (enab_prof_in),
    .enab_prof_out   (enab_prof_out)
  );

endmodule

// File: test/ref_fetch_checker.sv
`timescale 1ns/1ps

module ref_fetch_checker (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 load_ref_ram,
  input  logic [ref_pkg::ADDR_W-1:0]           load_addr,
  input  ref_pkg::ref_line_t                   load_line,
  input  logic                                 en,
  input  logic                                 export_data_ref,
  input  logic [ref_pkg::ADDR_W-1:0]           ref_4para_addr,
  input  logic [ref_pkg::POS_W-1:0]            pos_4,
  input  logic [ref_pkg::WIN_W-1:0]            ref_pel_4 [ref_pkg::WIN],
  input  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_in [ref_pkg::CUR_N],
  input  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_out [ref_pkg::CUR_N],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_x_in [ref_pkg::SUBBLK],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_y_in [ref_pkg::SUBBLK],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_x_out [ref_pkg::SUBBLK],
  input  logic signed [ref_pkg::MV_W-1:0]      mv_y_out [ref_pkg::SUBBLK],
  input  logic [ref_pkg::FRAC_W-1:0]           frac_x_in,
  input  logic [ref_pkg::FRAC_W-1:0]           frac_y_in,
  input  logic [ref_pkg::FRAC_W-1:0]           frac_x_out,
  input  logic [ref_pkg::FRAC_W-1:0]           frac_y_out,
  input  logic                                 enab_prof_in,
  input  logic                                 enab_prof_out,
  output int                                   errors
);

  // model of the line memory and of every output register
  logic [ref_pkg::LINE_W-1:0]          mem_model [ref_pkg::REF_DEPTH];
  logic [ref_pkg::WIN_W-1:0]           exp_pel [ref_pkg::WIN];
  logic [ref_pkg::CUR_ADDR_W-1:0]      exp_cur [ref_pkg::CUR_N];
  logic signed [ref_pkg::MV_W-1:0]     exp_mv_x [ref_pkg::SUBBLK];
  logic signed [ref_pkg::MV_W-1:0]     exp_mv_y [ref_pkg::SUBBLK];
  logic [ref_pkg::FRAC_W-1:0]          exp_frac_x;
  logic [ref_pkg::FRAC_W-1:0]          exp_frac_y;
  logic                                exp_prof;
  int                                  err_cnt = 0;

  assign errors = err_cnt;

  // window row from the linear pixel order, 16 pixels per line
  function automatic logic [ref_pkg::WIN_W-1:0] model_row(input int r,
      input logic [ref_pkg::ADDR_W-1:0] addr, input logic [ref_pkg::POS_W-1:0] pos);
    int                          b;
    int                          lin;
    int                          lane;
    logic [ref_pkg::ADDR_W-1:0]  line_a;
    logic [ref_pkg::LINE_W-1:0]  w;
    logic [ref_pkg::WIN_W-1:0]   row;
    row = '0;
    b = (int'(addr) + (r - 2) * 16 + 4096) % 4096;
    for (int m = 0; m < 9; m++)
    begin
      // wraps over the full 4096 line space
      lin = (16 * b + 13 - int'(pos) + m + 65536) % 65536;
      line_a = 12'(lin / 16);
      lane = 15 - (lin % 16);
      w = mem_model[line_a];
      row = {row[63:0], 8'(w >> (8 * lane))};
    end
    return row;
  endfunction

  task automatic check_val(input string name, input logic [71:0] exp_v,
      input logic [71:0] act_v);
    if (act_v !== exp_v)
    begin
      $display("[ERROR] %s expected %0h actual %0h", name, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic compare_outputs();
    for (int r = 0; r < ref_pkg::WIN; r++)
    begin
      check_val($sformatf("ref_pel_4[%0d]", r), exp_pel[r], ref_pel_4[r]);
    end
    for (int i = 0; i < ref_pkg::CUR_N; i++)
    begin
      check_val($sformatf("cur_addr_out[%0d]", i), 72'(exp_cur[i]), 72'(cur_addr_out[i]));
    end
    for (int i = 0; i < ref_pkg::SUBBLK; i++)
    begin
      check_val($sformatf("mv_x_out[%0d]", i), 72'($unsigned(exp_mv_x[i])),
                72'($unsigned(mv_x_out[i])));
      check_val($sformatf("mv_y_out[%0d]", i), 72'($unsigned(exp_mv_y[i])),
                72'($unsigned(mv_y_out[i])));
    end
    check_val("frac_x_out", 72'(exp_frac_x), 72'(frac_x_out));
    check_val("frac_y_out", 72'(exp_frac_y), 72'(frac_y_out));
    check_val("enab_prof_out", 72'(exp_prof), 72'(enab_prof_out));
  endtask

  // outputs seen here come from the previous edge, so compare first, then advance
  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      exp_pel = '{default: '0};
      exp_cur = '{default: '0};
      exp_mv_x = '{default: '0};
      exp_mv_y = '{default: '0};
      exp_frac_x = '0;
      exp_frac_y = '0;
      exp_prof = 1'b0;
    end
    else
    begin
      compare_outputs();
      // window reads memory before a write on the same edge
      if (en && export_data_ref)
      begin
        for (int r = 0; r < ref_pkg::WIN; r++)
        begin
          exp_pel[r] = model_row(r, ref_4para_addr, pos_4);
        end
      end
      if (export_data_ref)
      begin
        exp_cur = cur_addr_in;
        exp_mv_x = mv_x_in;
        exp_mv_y = mv_y_in;
        exp_frac_x = frac_x_in;
        exp_frac_y = frac_y_in;
        exp_prof = enab_prof_in;
      end
      if (load_ref_ram)
      begin
        mem_model[load_addr] = load_line.raw;
      end
    end
  end

endmodule

// File: test/tb_ref_fetch.sv
`timescale 1ns/1ps

module tb_ref_fetch;

  // run length bound from loads and fetch traffic
  localparam int LOAD_CYCLES = ref_pkg::REF_DEPTH;
  localparam int FETCH_CYCLES = 2000;
  localparam int CYCLE_LIMIT = 2 * (LOAD_CYCLES + FETCH_CYCLES) + 100;

  logic                                 clk = 1'b0;
  logic                                 rst_n;
  logic                                 load_ref_ram;
  logic [ref_pkg::ADDR_W-1:0]           load_addr;
  ref_pkg::ref_line_t                   load_line;
  logic                                 en;
  logic                                 export_data_ref;
  logic [ref_pkg::ADDR_W-1:0]           ref_4para_addr;
  logic [ref_pkg::POS_W-1:0]            pos_4;
  logic [ref_pkg::WIN_W-1:0]            ref_pel_4 [ref_pkg::WIN];
  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_in [ref_pkg::CUR_N];
  logic [ref_pkg::CUR_ADDR_W-1:0]       cur_addr_out [ref_pkg::CUR_N];
  logic signed [ref_pkg::MV_W-1:0]      mv_x_in [ref_pkg::SUBBLK];
  logic signed [ref_pkg::MV_W-1:0]      mv_y_in [ref_pkg::SUBBLK];
  logic signed [ref_pkg::MV_W-1:0]      mv_x_out [ref_pkg::SUBBLK];
  logic signed [ref_pkg::MV_W-1:0]      mv_y_out [ref_pkg::SUBBLK];
  logic [ref_pkg::FRAC_W-1:0]           frac_x_in;
  logic [ref_pkg::FRAC_W-1:0]           frac_y_in;
  logic [ref_pkg::FRAC_W-1:0]           frac_x_out;
  logic [ref_pkg::FRAC_W-1:0]           frac_y_out;
  logic                                 enab_prof_in;
  logic                                 enab_prof_out;
  int                                   errors;
  int                                   pass_count = 0;
  int                                   fail_count = 0;
  int                                   err_mark = 0;
  int                                   cycle_count = 0;

  always #20 clk = ~clk;

  ref_fetch_top u_dut (.*);

  ref_fetch_checker u_chk (.*);

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  task automatic drive_sideband();
    for (int i = 0; i < ref_pkg::CUR_N; i++)
    begin
      cur_addr_in[i] <= 13'($urandom);
    end
    for (int i = 0; i < ref_pkg::SUBBLK; i++)
    begin
      mv_x_in[i] <= 11'($urandom);
      mv_y_in[i] <= 11'($urandom);
    end
    frac_x_in <= 5'($urandom);
    frac_y_in <= 5'($urandom);
    enab_prof_in <= 1'($urandom);
  endtask

  // one strobe cycle, then strobes low for one cycle
  task automatic fetch_window(input logic [11:0] addr, input logic [3:0] pos);
    @(posedge clk);
    en <= 1'b1;
    export_data_ref <= 1'b1;
    ref_4para_addr <= addr;
    pos_4 <= pos;
    drive_sideband();
    @(posedge clk);
    en <= 1'b0;
    export_data_ref <= 1'b0;
  endtask

  // let the checker see the last result before counting
  task automatic finish_test(input string name);
    repeat (2) @(negedge clk);
    if (errors == err_mark)
    begin
      $display("test %s: pass", name);
      pass_count++;
    end
    else
    begin
      $display("test %s: fail with %0d mismatches", name, errors - err_mark);
      fail_count++;
    end
    err_mark = errors;
  endtask

  initial
  begin
    void'($urandom(32'h5f77));
    rst_n <= 1'b0;
    load_ref_ram <= 1'b0;
    load_addr <= '0;
    load_line <= '0;
    en <= 1'b0;
    export_data_ref <= 1'b0;
    ref_4para_addr <= '0;
    pos_4 <= '0;
    cur_addr_in <= '{default: '0};
    mv_x_in <= '{default: '0};
    mv_y_in <= '{default: '0};
    frac_x_in <= '0;
    frac_y_in <= '0;
    enab_prof_in <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    repeat (3) @(posedge clk);
    finish_test("reset_values");

    for (int a = 0; a < ref_pkg::REF_DEPTH; a++)
    begin
      @(posedge clk);
      load_ref_ram <= 1'b1;
      load_addr <= 12'(a);
      load_line.raw <= {$urandom, $urandom, $urandom, $urandom};
    end
    @(posedge clk);
    load_ref_ram <= 1'b0;
    // every position gets 50 fetches
    for (int i = 0; i < 800; i++)
    begin
      fetch_window(12'($urandom), 4'(i % 16));
    end
    finish_test("random_fetch");

    // first four near line 0, last four near line 4095
    for (int k = 0; k < 8; k++)
    begin
      for (int p = 0; p < 16; p++)
      begin
        fetch_window((k < 4) ? 12'(k * 16) : 12'(4095 - (k - 4) * 16), 4'(p));
      end
    end
    finish_test("address_wrap");

    for (int i = 0; i < 20; i++)
    begin
      @(posedge clk);
      export_data_ref <= 1'b1;
      ref_4para_addr <= 12'($urandom);
      pos_4 <= 4'($urandom);
      drive_sideband();
      @(posedge clk);
      export_data_ref <= 1'b0;
    end
    // fetch enable alone must not move anything
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      en <= 1'b1;
      ref_4para_addr <= 12'($urandom);
      pos_4 <= 4'($urandom);
      drive_sideband();
    end
    @(posedge clk);
    en <= 1'b0;
    finish_test("sideband_hold");

    for (int i = 0; i < 10; i++)
    begin
      logic [ref_pkg::ADDR_W-1:0] same_line;
      same_line = ref_pkg::ADDR_W'($urandom);
      // write and fetch the same line on one edge
      @(posedge clk);
      load_ref_ram <= 1'b1;
      load_addr <= same_line;
      load_line.raw <= {$urandom, $urandom, $urandom, $urandom};
      en <= 1'b1;
      export_data_ref <= 1'b1;
      ref_4para_addr <= same_line;
      pos_4 <= 4'($urandom);
      @(posedge clk);
      load_ref_ram <= 1'b0;
      en <= 1'b0;
      export_data_ref <= 1'b0;
      fetch_window(same_line, pos_4);
    end
    finish_test("write_then_fetch");

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0)
    begin
      $display("Everything OK");
    end
    else
    begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: src.f
hw/ref_pkg.sv
hw/ref_line_ram.sv
hw/ref_row_align.sv
hw/ref_window_gather.sv
hw/ref_sideband_fwd.sv
hw/ref_fetch_top.sv
test/ref_fetch_checker.sv
test/tb_ref_fetch.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_ref_fetch -o tb_ref_fetch
out=$(./obj_dir/tb_ref_fetch)
echo "$out"

if echo "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
